// File: design/board_pkg.sv
// ========================================
// host register map and bus widths
// address bits 3..0 offset, 7..4 channel
// bits 15..8 must be zero or the access is dropped
// channel 0 is the board, channels 1..NUM_MOTORS motors
// ========================================
`default_nettype none

package board_pkg;

   localparam int ADDR_BITS = 16;   // host address bus
   localparam int DATA_BITS = 32;   // host data bus
   localparam int OFS_BITS  = 4;    // register offset field
   localparam int CHAN_LSB  = 4;    // channel field starts here
   localparam int UPPER_LSB = 8;    // reserved bits, must be zero

   typedef logic [ADDR_BITS-1:0] addr_t;
   typedef logic [DATA_BITS-1:0] data_t;
   typedef logic [OFS_BITS-1:0]  ofs_t;

   // decoded write target
   typedef enum logic [2:0] {
      FIELD_DUTY,
      FIELD_AMP_EN,
      FIELD_WDOG_PERIOD,
      FIELD_WDOG_CLEAR,
      FIELD_NONE
   } reg_field_e;

   localparam int BOARD_CHAN = 0;   // channel number of board regs

   // board register offsets
   localparam ofs_t OFS_STATUS      = 4'd0;
   localparam ofs_t OFS_WDOG_PERIOD = 4'd1;
   localparam ofs_t OFS_TIMESTAMP   = 4'd2;
   localparam ofs_t OFS_WDOG_CLEAR  = 4'd3;   // write only

   // per motor offsets
   localparam ofs_t OFS_DUTY   = 4'd0;
   localparam ofs_t OFS_AMP_EN = 4'd1;

   localparam int STAT_TIMEOUT_BIT = 8;   // timeout flag in status word

endpackage

`default_nettype wire

// File: design/motor_pkg.sv
// ========================================
// motor channel and watchdog definitions
// PWM period is 2**PWM_BITS sysclk cycles
// watchdog period of zero turns it off
// ========================================
`default_nettype none

package motor_pkg;

   localparam int NUM_MOTORS = 4;    // motor channels 1..4
   localparam int PWM_BITS   = 8;    // shared pwm counter width
   localparam int CHAN_BITS  = 4;    // channel index width
   localparam int WDOG_BITS  = 16;   // watchdog period / counter

   typedef logic [PWM_BITS-1:0]  duty_t;
   typedef logic [CHAN_BITS-1:0] chan_t;
   typedef logic [WDOG_BITS-1:0] wdog_cnt_t;

   // host watchdog states
   typedef enum logic [1:0] {
      WD_OFF,       // period zero, never fires
      WD_ARMED,     // counting down
      WD_TIMEOUT    // fired, amps killed
   } wdog_state_e;

endpackage

`default_nettype wire

// File: design/drac_if.sv
// ========================================
// internal buses between the design blocks
// wr_cmd_if valid is a single cycle strobe
// no handshake, sinks take every command
// ========================================
`timescale 1ns/1ps
`default_nettype none

// decoded host write, one per cycle at most
interface wr_cmd_if import board_pkg::*, motor_pkg::*;
   ;
   logic       valid;   // one cycle strobe
   reg_field_e field;   // target register
   chan_t      chan;    // motor channel, 0 for board regs
   data_t      data;    // write payload

   modport source (output valid, field, chan, data);
   modport sink   (input  valid, field, chan, data);
endinterface

// live motor and watchdog state for the read side
interface motor_status_if import motor_pkg::*;
   ;
   duty_t [NUM_MOTORS-1:0] duty;     // per channel duty
   logic  [NUM_MOTORS-1:0] amp_en;   // effective enables, forced low on timeout
   logic                   wdog_timeout;
   wdog_cnt_t              wdog_period;

   // bank also reads the timeout as its amp kill
   modport bank   (output duty, amp_en, input wdog_timeout);
   modport wdog   (output wdog_timeout, wdog_period);
   modport reader (input  duty, amp_en, wdog_timeout, wdog_period);
endinterface

`default_nettype wire

// File: design/reg_write_decode.sv
// ========================================
// host write decoder, one cycle registered
// illegal addresses give no command
// activity pulses on every reg_wen anyway
// ========================================
`timescale 1ns/1ps
`default_nettype none

module reg_write_decode
   import board_pkg::*;
   import motor_pkg::*;
(
   input  logic     sysclk,
   input  logic     rst_n,
   input  addr_t    reg_waddr,
   input  data_t    reg_wdata,
   input  logic     reg_wen,
   wr_cmd_if.source cmd,
   output logic     activity    // host alive pulse for the watchdog
);

   ofs_t       ofs;
   chan_t      chan;
   logic       upper_zero;
   reg_field_e field_d;

   assign ofs        = reg_waddr[OFS_BITS-1:0];
   assign chan       = reg_waddr[CHAN_LSB +: CHAN_BITS];
   assign upper_zero = (reg_waddr[ADDR_BITS-1:UPPER_LSB] == '0);

   // address to field
   always_comb begin
      field_d = FIELD_NONE;
      if (upper_zero) begin
         if (chan == chan_t'(BOARD_CHAN)) begin
            case (ofs)
               OFS_WDOG_PERIOD: field_d = FIELD_WDOG_PERIOD;
               OFS_WDOG_CLEAR:  field_d = FIELD_WDOG_CLEAR;
               default:         field_d = FIELD_NONE;   // status, timestamp read only
            endcase
         end else if (int'(chan) <= NUM_MOTORS) begin
            case (ofs)
               OFS_DUTY:   field_d = FIELD_DUTY;
               OFS_AMP_EN: field_d = FIELD_AMP_EN;
               default:    field_d = FIELD_NONE;
            endcase
         end
      end
   end

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         cmd.valid <= 1'b0;
         cmd.field <= FIELD_NONE;
         activity  <= 1'b0;
      end else begin
         cmd.valid <= reg_wen && (field_d != FIELD_NONE);
         cmd.field <= reg_wen ? field_d : FIELD_NONE;
         activity  <= reg_wen;   // legal or not
      end
   end

   // payload, qualified by valid
   always_ff @(posedge sysclk) begin
      cmd.chan <= chan;
      cmd.data <= reg_wdata;
   end

   // sinks index motors by chan without range checks
   a_cmd_chan_legal: assert property (@(posedge sysclk) disable iff (!rst_n)
      cmd.valid |-> (int'(cmd.chan) <= NUM_MOTORS));

endmodule

`default_nettype wire

// File: design/watchdog_timer.sv
// ========================================
// host silence watchdog
// fires period cycles after the last write
// sticky until a clear or a new period write
// host activity is ignored once fired
// ========================================
`timescale 1ns/1ps
`default_nettype none

module watchdog_timer
   import board_pkg::*;
   import motor_pkg::*;
(
   input  logic          sysclk,
   input  logic          rst_n,
   wr_cmd_if.sink        cmd,
   input  logic          activity,
   motor_status_if.wdog  status,
   output logic          wdog_led
);

   wdog_state_e state;
   wdog_cnt_t   period_q;
   wdog_cnt_t   cnt_q;       // cycles left before timeout
   logic        timeout_q;
   logic        wr_period;
   logic        wr_clear;

   assign wr_period = cmd.valid && (cmd.field == FIELD_WDOG_PERIOD);
   assign wr_clear  = cmd.valid && (cmd.field == FIELD_WDOG_CLEAR);

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= WD_OFF;
         period_q  <= '0;
         cnt_q     <= '0;
         timeout_q <= 1'b0;
      end else if (wr_period) begin
         // new period rearms, zero turns it off
         period_q  <= cmd.data[WDOG_BITS-1:0];
         cnt_q     <= cmd.data[WDOG_BITS-1:0];
         timeout_q <= 1'b0;
         state     <= (cmd.data[WDOG_BITS-1:0] == '0) ? WD_OFF : WD_ARMED;
      end else begin
         case (state)
            WD_ARMED: begin
               if (activity) begin
                  cnt_q <= period_q;   // restart
               end else if (cnt_q == wdog_cnt_t'(1)) begin
                  state     <= WD_TIMEOUT;
                  timeout_q <= 1'b1;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            WD_TIMEOUT: if (wr_clear) begin
               state     <= WD_ARMED;   // period nonzero here
               timeout_q <= 1'b0;
               cnt_q     <= period_q;
            end
            default: ;   // off stays off until a period write
         endcase
      end
   end

   assign status.wdog_timeout = timeout_q;
   assign status.wdog_period  = period_q;
   assign wdog_led            = timeout_q;

   a_off_no_timeout: assert property (@(posedge sysclk) disable iff (!rst_n)
      (state == WD_OFF) |-> !timeout_q);

endmodule

`default_nettype wire

// File: design/motor_pwm_bank.sv
// ========================================
// motor duty / enable registers and PWM
// one shared free running counter
// output high while count below duty
// duty 0 always low, never fully on
// timeout clears all enables, rewrite needed
// ========================================
`timescale 1ns/1ps
`default_nettype none

module motor_pwm_bank
   import board_pkg::*;
   import motor_pkg::*;
(
   input  logic                   sysclk,
   input  logic                   rst_n,
   wr_cmd_if.sink                 cmd,
   motor_status_if.bank           status,
   output logic [NUM_MOTORS-1:0]  pwm_out
);

   duty_t [NUM_MOTORS-1:0] duty_q;
   logic  [NUM_MOTORS-1:0] amp_en_q;   // host requested enables
   logic  [NUM_MOTORS-1:0] en_eff;     // after watchdog kill
   logic  [PWM_BITS-1:0]   pwm_cnt;
   logic                   amp_kill;
   logic                   wr_duty;
   logic                   wr_en;

   assign amp_kill = status.wdog_timeout;
   assign wr_duty  = cmd.valid && (cmd.field == FIELD_DUTY);
   assign wr_en    = cmd.valid && (cmd.field == FIELD_AMP_EN);

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         duty_q   <= '0;
         amp_en_q <= '0;
         pwm_cnt  <= '0;
      end else begin
         pwm_cnt <= pwm_cnt + 1'b1;   // wraps every 2**PWM_BITS
         for (int i = 0; i < NUM_MOTORS; i++) begin
            // channel i+1 on the host bus
            if (wr_duty && (int'(cmd.chan) == i + 1)) begin
               duty_q[i] <= cmd.data[PWM_BITS-1:0];   // still allowed on timeout
            end
            if (amp_kill) begin
               amp_en_q[i] <= 1'b0;
            end else if (wr_en && (int'(cmd.chan) == i + 1)) begin
               amp_en_q[i] <= cmd.data[0];
            end
         end
      end
   end

   // mask right away, the register clears one cycle later
   assign en_eff = amp_en_q & ~{NUM_MOTORS{amp_kill}};

   always_comb begin
      for (int i = 0; i < NUM_MOTORS; i++) begin
         pwm_out[i] = en_eff[i] && (pwm_cnt < duty_q[i]);
      end
   end

   assign status.duty   = duty_q;
   assign status.amp_en = en_eff;

   a_pwm_needs_en: assert property (@(posedge sysclk) disable iff (!rst_n)
      (pwm_out & ~amp_en_q) == '0);

   // watchdog fire must reach every channel at once
   a_kill_all: assert property (@(posedge sysclk) disable iff (!rst_n)
      amp_kill |-> (status.amp_en == '0) && (pwm_out == '0));

endmodule

`default_nettype wire

// File: design/reg_read_mux.sv
// ========================================
// register read back and timestamp
// fixed one cycle read latency
// timestamp wraps at 2**32 cycles
// illegal or write only addresses read 0
// ========================================
`timescale 1ns/1ps
`default_nettype none

module reg_read_mux
   import board_pkg::*;
   import motor_pkg::*;
(
   input  logic           sysclk,
   input  logic           rst_n,
   input  addr_t          reg_raddr,
   motor_status_if.reader status,
   output data_t          reg_rdata
);

   data_t ts_q;        // free running timestamp
   data_t rdata_d;
   ofs_t  ofs;
   chan_t chan;
   logic  upper_zero;

   assign ofs        = reg_raddr[OFS_BITS-1:0];
   assign chan       = reg_raddr[CHAN_LSB +: CHAN_BITS];
   assign upper_zero = (reg_raddr[ADDR_BITS-1:UPPER_LSB] == '0);

   always_comb begin
      rdata_d = '0;
      if (upper_zero) begin
         if (chan == chan_t'(BOARD_CHAN)) begin
            case (ofs)
               OFS_STATUS: begin
                  rdata_d[NUM_MOTORS-1:0]   = status.amp_en;
                  rdata_d[STAT_TIMEOUT_BIT] = status.wdog_timeout;
               end
               OFS_WDOG_PERIOD: rdata_d[WDOG_BITS-1:0] = status.wdog_period;
               OFS_TIMESTAMP:   rdata_d = ts_q;
               default:         rdata_d = '0;   // clear reg included
            endcase
         end else begin
            for (int i = 0; i < NUM_MOTORS; i++) begin
               if (int'(chan) == i + 1) begin
                  case (ofs)
                     OFS_DUTY:   rdata_d[PWM_BITS-1:0] = status.duty[i];
                     OFS_AMP_EN: rdata_d[0]            = status.amp_en[i];
                     default:    ;
                  endcase
               end
            end
         end
      end
   end

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         ts_q      <= '0;
         reg_rdata <= '0;
      end else begin
         ts_q      <= ts_q + 1'b1;
         reg_rdata <= rdata_d;
      end
   end

endmodule

`default_nettype wire

// File: design/drac_lite_top.sv
// ========================================
// reduced motor controller board top
// single clock domain on sysclk
// host bus has no wait states or handshake
// write lands 2 cycles after reg_wen
// read data 1 cycle after reg_raddr
// ========================================
`timescale 1ns/1ps
`default_nettype none

module drac_lite_top
   import board_pkg::*;
   import motor_pkg::*;
(
   input  logic                  sysclk,
   input  logic                  rst_n,
   // host write port
   input  addr_t                 reg_waddr,
   input  data_t                 reg_wdata,
   input  logic                  reg_wen,
   // host read port
   input  addr_t                 reg_raddr,
   output data_t                 reg_rdata,
   // board outputs
   output logic [NUM_MOTORS-1:0] pwm_out,
   output logic                  wdog_led
);

   logic activity;   // any host write, decoded or not

   wr_cmd_if       cmd_if ();
   motor_status_if stat_if ();

   reg_write_decode u_wr_dec (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .reg_waddr (reg_waddr),
      .reg_wdata (reg_wdata),
      .reg_wen   (reg_wen),
      .cmd       (cmd_if.source),
      .activity  (activity)
   );

   watchdog_timer u_wdog (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .cmd      (cmd_if.sink),
      .activity (activity),
      .status   (stat_if.wdog),
      .wdog_led (wdog_led)
   );

   motor_pwm_bank u_bank (
      .sysclk  (sysclk),
      .rst_n   (rst_n),
      .cmd     (cmd_if.sink),
      .status  (stat_if.bank),
      .pwm_out (pwm_out)
   );

   reg_read_mux u_rd_mux (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .reg_raddr (reg_raddr),
      .status    (stat_if.reader),
      .reg_rdata (reg_rdata)
   );

endmodule

`default_nettype wire

// File: test/tb_drac_lite.sv
// ========================================
// testbench for drac_lite_top
// inputs change on the falling edge only
// model tracks duty, enable, period, timeout
// writes land 2 edges after reg_wen
// watchdog timing checked to the cycle
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_drac_lite
   import board_pkg::*;
   import motor_pkg::*;
();

   localparam int        CLK_PERIOD = 4;
   localparam wdog_cnt_t WD_PERIOD  = 16'd40;
   localparam int        PWM_WIN    = 1 << PWM_BITS;   // one full pwm period
   localparam int        ZERO_WAIT  = 200;
   localparam int        GAP        = 20;   // idle between illegal writes, below WD_PERIOD
   localparam int        KMAX       = 50;
   localparam addr_t     BAD_ADDR [6] = '{16'h0110, 16'h0050, 16'h0012,
                                          16'h0002, 16'h0000, 16'h00f1};
   // cycle budget per test, doubled for the run limit
   localparam int RUN_CYCLES = 8 + NUM_MOTORS * 8 + 4 * 4 + 4 * 12   // reset, readback
                             + 2 * (PWM_WIN + 8)                       // pwm counts
                             + int'(WD_PERIOD) + PWM_WIN + 24          // timeout
                             + ZERO_WAIT + 24                          // clear, period 0
                             + 6 * (GAP + 1) + 24                      // illegal writes
                             + 3 * (KMAX + 4);                         // timestamp
   localparam int RUN_LIMIT_NS = 2 * RUN_CYCLES * CLK_PERIOD;

   logic                  sysclk;
   logic                  rst_n;
   addr_t                 reg_waddr;
   data_t                 reg_wdata;
   logic                  reg_wen;
   addr_t                 reg_raddr;
   data_t                 reg_rdata;
   logic [NUM_MOTORS-1:0] pwm_out;
   logic                  wdog_led;

   // reference model
   duty_t     exp_duty [1:NUM_MOTORS];
   logic      exp_en   [1:NUM_MOTORS];
   wdog_cnt_t exp_period;
   logic      exp_timeout;

   int n_checks = 0;
   int n_errors = 0;
   int seed     = 15;

   drac_lite_top DUT (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .reg_waddr (reg_waddr),
      .reg_wdata (reg_wdata),
      .reg_wen   (reg_wen),
      .reg_raddr (reg_raddr),
      .reg_rdata (reg_rdata),
      .pwm_out   (pwm_out),
      .wdog_led  (wdog_led)
   );

   initial begin
      sysclk = 1'b0;
      forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
   end

   // killed amps never switch
   a_kill_pwm_low: assert property (@(negedge sysclk) disable iff (!rst_n)
      wdog_led |-> (pwm_out == '0))
   else begin
      $display("Fail pwm_out: %h while wdog_led high", pwm_out);
      n_errors++;
   end

   function automatic addr_t reg_addr(input int chan, input ofs_t ofs);
      return addr_t'(chan << CHAN_LSB) | addr_t'(ofs);
   endfunction

   // status word: enables low bits, timeout flag
   function automatic data_t status_word();
      data_t w;
      w = '0;
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         w[ch-1] = exp_en[ch];
      end
      w[STAT_TIMEOUT_BIT] = exp_timeout;
      return w;
   endfunction

   task automatic check_val(input string name, input data_t got, input data_t exp);
      n_checks++;
      assert (got == exp) else begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         n_errors++;
      end
   endtask

   // one write strobe, returns at the next falling edge
   task automatic write_reg(input addr_t addr, input data_t data);
      reg_waddr = addr;
      reg_wdata = data;
      reg_wen   = 1'b1;
      @(negedge sysclk);
      reg_wen   = 1'b0;
   endtask

   task automatic read_reg(input addr_t addr, output data_t data);
      reg_raddr = addr;
      @(posedge sysclk);   // address sampled here
      @(negedge sysclk);   // rdata stable
      data = reg_rdata;
   endtask

   task automatic check_reg(input addr_t addr, input data_t exp, input string name);
      data_t got;
      read_reg(addr, got);
      check_val($sformatf("reg_rdata %s at %h", name, addr), got, exp);
   endtask

   task automatic set_duty(input int ch, input duty_t d);
      write_reg(reg_addr(ch, OFS_DUTY), data_t'(d));
      exp_duty[ch] = d;   // applies even on timeout
   endtask

   task automatic set_en(input int ch, input logic e);
      write_reg(reg_addr(ch, OFS_AMP_EN), data_t'(e));
      if (!exp_timeout) begin
         exp_en[ch] = e;
      end
   endtask

   task automatic set_period(input wdog_cnt_t p);
      write_reg(reg_addr(BOARD_CHAN, OFS_WDOG_PERIOD), data_t'(p));
      exp_period  = p;
      exp_timeout = 1'b0;   // rearm
   endtask

   task automatic clear_wdog();
      write_reg(reg_addr(BOARD_CHAN, OFS_WDOG_CLEAR), '0);
      exp_timeout = 1'b0;
   endtask

   task automatic check_all();
      check_reg(reg_addr(BOARD_CHAN, OFS_STATUS), status_word(), "status");
      check_reg(reg_addr(BOARD_CHAN, OFS_WDOG_PERIOD), data_t'(exp_period), "wdog_period");
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         check_reg(reg_addr(ch, OFS_DUTY), data_t'(exp_duty[ch]), "duty");
         check_reg(reg_addr(ch, OFS_AMP_EN), data_t'(exp_en[ch]), "amp_en");
      end
   endtask

   // high cycles per channel over one full pwm period
   task automatic count_pwm();
      int high_cnt [1:NUM_MOTORS];
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         high_cnt[ch] = 0;
      end
      repeat (PWM_WIN) begin
         @(negedge sysclk);
         for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
            if (pwm_out[ch-1]) high_cnt[ch]++;
         end
      end
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         check_val($sformatf("pwm_out[%0d] high cycles", ch - 1), data_t'(high_cnt[ch]),
                   exp_en[ch] ? data_t'(exp_duty[ch]) : data_t'(0));
      end
   endtask

   initial begin
      #(RUN_LIMIT_NS);
      $display("run limit of %0d ns reached, simulation stuck", RUN_LIMIT_NS);
      $display("Errors found");
      $finish;
   end

   initial begin
      data_t t0;
      data_t t1;
      int    k;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_wen   = 1'b0;
      reg_raddr = '0;
      rst_n     = 1'b0;
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         exp_duty[ch] = '0;
         exp_en[ch]   = 1'b0;
      end
      exp_period  = '0;
      exp_timeout = 1'b0;
      repeat (8) @(negedge sysclk);
      rst_n = 1'b1;
      check_val("pwm_out after reset", data_t'(pwm_out), '0);
      check_val("wdog_led after reset", data_t'(wdog_led), '0);
      check_val("reg_rdata after reset", reg_rdata, '0);
      check_all();

      // duty and enable readback per channel
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         set_duty(ch, duty_t'($random(seed)));
         set_en(ch, 1'($random(seed)));
         @(negedge sysclk);   // enable lands on this edge
         check_reg(reg_addr(ch, OFS_DUTY), data_t'(exp_duty[ch]), "duty");
         check_reg(reg_addr(ch, OFS_AMP_EN), data_t'(exp_en[ch]), "amp_en");
      end
      repeat (4) begin   // random channel order
         k = 1 + int'($unsigned($random(seed)) % NUM_MOTORS);
         set_duty(k, duty_t'($random(seed)));
         @(negedge sysclk);
         check_reg(reg_addr(k, OFS_DUTY), data_t'(exp_duty[k]), "duty");
      end
      check_all();

      // pwm counts, then every enable flipped
      count_pwm();
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         set_en(ch, ~exp_en[ch]);
      end
      repeat (2) @(negedge sysclk);
      count_pwm();

      // host goes silent with ch1 switching
      set_duty(1, 8'h80);
      set_en(1, 1'b1);
      set_period(WD_PERIOD);
      // restart lands one edge after the strobe, fire period edges later
      repeat (WD_PERIOD) @(negedge sysclk);
      check_val("wdog_led one cycle early", data_t'(wdog_led), '0);
      @(negedge sysclk);
      check_val("wdog_led at period", data_t'(wdog_led), data_t'(1));
      exp_timeout = 1'b1;
      for (int ch = 1; ch <= NUM_MOTORS; ch++) begin
         exp_en[ch] = 1'b0;   // kill clears the enable registers
      end
      set_en(2, 1'b1);   // dropped
      set_duty(2, duty_t'($random(seed)));
      @(negedge sysclk);
      check_all();
      count_pwm();

      // clear, reenable, then period 0 never fires
      clear_wdog();
      set_en(1, 1'b1);
      @(negedge sysclk);
      check_val("wdog_led after clear", data_t'(wdog_led), '0);
      check_reg(reg_addr(BOARD_CHAN, OFS_STATUS), status_word(), "status");
      check_reg(reg_addr(1, OFS_AMP_EN), data_t'(exp_en[1]), "amp_en");
      set_period(16'd0);
      repeat (ZERO_WAIT) @(negedge sysclk);
      check_val("wdog_led with period 0", data_t'(wdog_led), '0);
      check_all();

      // illegal writes keep the watchdog fed but change nothing
      set_period(WD_PERIOD);
      for (int i = 0; i < 6; i++) begin
         write_reg(BAD_ADDR[i], data_t'($random(seed)));
         repeat (GAP) @(negedge sysclk);
      end
      check_val("wdog_led after illegal writes", data_t'(wdog_led), '0);
      set_period(16'd0);
      @(negedge sysclk);
      check_all();
      check_reg(BAD_ADDR[0], '0, "upper bits set");

      // timestamp delta equals read spacing
      repeat (3) begin
         k = 1 + int'($unsigned($random(seed)) % KMAX);
         read_reg(reg_addr(BOARD_CHAN, OFS_TIMESTAMP), t0);
         repeat (k - 1) @(negedge sysclk);
         read_reg(reg_addr(BOARD_CHAN, OFS_TIMESTAMP), t1);
         check_val("timestamp delta", t1 - t0, data_t'(k));
      end

      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
design/board_pkg.sv
design/motor_pkg.sv
design/drac_if.sv
design/reg_write_decode.sv
design/watchdog_timer.sv
design/motor_pwm_bank.sv
design/reg_read_mux.sv
design/drac_lite_top.sv
test/tb_drac_lite.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_drac_lite with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_drac_lite
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/Vtb_drac_lite)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
   exit 0
fi
echo "simulation did not report a clean run"
exit 1
